// ==== Bender.yml ====
package:
  name: frontpanel_interface

sources:
  - verilog/fp_types_pkg.sv
  - verilog/fp_ep_map_pkg.sv
  - verilog/host_cmd_fsm.sv
  - verilog/pipe_credit_counter.sv
  - verilog/endpoint_regs.sv
  - verilog/pipe_tx_fifo.sv
  - verilog/frontpanel_interface.sv
  - target: simulation
    files:
      - testbench/tb_frontpanel_interface.sv

// ==== tb.f ====
verilog/fp_types_pkg.sv
verilog/fp_ep_map_pkg.sv
verilog/host_cmd_fsm.sv
verilog/pipe_credit_counter.sv
verilog/endpoint_regs.sv
verilog/pipe_tx_fifo.sv
verilog/frontpanel_interface.sv
testbench/tb_frontpanel_interface.sv

// ==== testbench/fp_tests.txt ====
# columns in hex: op addr data expected err
# op 0 wire-in, 1 trigger, 2 wire-out, 3 credit, 4 samples, 5 channel read, 6 stream, 7 drain
# write every wire-in register
0 00 0005 0000 0
0 01 12ff 0000 0
0 02 0400 0000 0
0 03 002a 0000 0
0 04 0081 0000 0
0 05 7fff 0000 0
0 06 fc18 0000 0
0 07 0123 0000 0
0 08 8001 0000 0
0 09 0003 0000 0
0 0a 00c3 0000 0
0 0b 005a 0000 0
# read them back, narrow fields truncated
2 00 0000 0005 0
2 01 0000 00ff 0
2 02 0000 0400 0
2 03 0000 002a 0
2 04 0000 0081 0
2 05 0000 7fff 0
2 06 0000 fc18 0
2 07 0000 0123 0
2 08 0000 8001 0
2 09 0000 0003 0
2 0a 0000 00c3 0
2 0b 0000 005a 0
# triggers, expected is the packed trig word
1 40 0001 0400 0
1 41 00a5 0294 0
1 42 0001 0002 0
# update enables, expected is pid mask over osf mask
0 05 7fff 0000 0
0 05 1234 5a00 0
0 02 0400 0000 0
0 02 0401 00c3 0
0 09 0003 0000 0
# channel samples
4 00 0089 0000 0
4 00 0018 0000 0
5 20 0000 0000 0
5 21 0000 0000 0
5 22 0000 0000 0
5 23 0000 0000 0
5 24 0000 0000 0
5 25 0000 0000 0
5 26 0000 0000 0
5 27 0000 0000 0
4 00 0066 0000 0
5 21 0000 0000 0
5 26 0000 0000 0
# pipe stream under credit control
1 43 0001 0001 0
6 00 000c 0000 0
2 28 0000 000c 0
3 00 0005 0000 0
7 00 0005 0000 0
2 28 0000 0007 0
3 00 0007 0000 0
7 00 0007 0000 0
# overflow with no credit
6 00 0014 0000 0
2 28 0000 0110 0
3 00 0010 0000 0
7 00 0010 0000 0
2 28 0000 0100 0
# unmapped addresses
0 30 1111 0000 1
1 44 0001 0000 1
2 29 0000 0000 1
2 40 0000 0000 1
# sys_reset clears level, overflow and credits
6 00 0004 0000 0
2 28 0000 0104 0
1 43 0001 0001 0
2 28 0000 0000 0
3 00 0002 0000 0
2 28 0000 0200 0
1 43 0001 0001 0
2 28 0000 0000 0
6 00 0003 0000 0
2 28 0000 0003 0
3 00 0003 0000 0
7 00 0003 0000 0
2 28 0000 0000 0

// ==== testbench/tb_frontpanel_interface.sv ====
`default_nettype none

module tb_frontpanel_interface;

	timeunit 1ns;
	timeprecision 1ps;

	import fp_types_pkg::*;
	import fp_ep_map_pkg::*;

	localparam int          CYCLES_PER_STEP = 200;
	localparam int          CYCLES_BASE     = 2000;
	localparam int          RESET_CYCLES    = 8;
	localparam int          RSP_LATENCY     = 2;              // accept edge to response edge
	localparam int          QUIET_CYCLES    = 20;             // pipe must stay idle after a drain
	localparam logic [31:0] LFSR_SEED       = 32'h961b706b;

	// step codes above the host ops, handled by the testbench itself
	localparam int STEP_SAMPLES = 4;                         // data is the valid mask
	localparam int STEP_READ_CH = 5;                         // expected from the sample model
	localparam int STEP_STREAM  = 6;                         // data is the sample count
	localparam int STEP_DRAIN   = 7;                         // data is the word count

	typedef struct packed {
		logic [3:0] op;
		ep_addr_t   addr;
		ep_data_t   data;
		ep_data_t   exp;
		logic       err;
	} step_t;

	logic                  clk;
	logic                  rst;
	host_req_t             host_req;
	host_rsp_t             host_rsp;
	chan_mask_t            osf_valid;
	adc_data_t [N_ADC-1:0] osf_data_packed;
	adc_cfg_t              adc_cfg;
	osf_cfg_t              osf_cfg;
	pid_cfg_t              pid_cfg;
	chan_mask_t            osf_update_en;
	chan_mask_t            pid_update_en;
	trig_t                 trig;
	pipe_word_t            pipe_out;

	step_t       steps[$];
	bit          loaded;
	int          step_limit;
	logic [31:0] lfsr_state;

	// expected state, built from the host writes and the samples
	adc_cfg_t              exp_adc;
	osf_cfg_t              exp_osf;
	pid_cfg_t              exp_pid;
	logic [W_CHAN_SEL-1:0] exp_sel;
	ep_data_t              exp_chan [N_ADC];
	ep_data_t              exp_pipe[$];
	int                    granted;                           // credits since last flush
	int                    rx_count;                          // pipe words since last flush
	int                    rx_mark;

	frontpanel_interface dut (
		.clk50_in        (clk),
		.rst             (rst),
		.host_req        (host_req),
		.host_rsp        (host_rsp),
		.osf_valid       (osf_valid),
		.osf_data_packed (osf_data_packed),
		.adc_cfg         (adc_cfg),
		.osf_cfg         (osf_cfg),
		.pid_cfg         (pid_cfg),
		.osf_update_en   (osf_update_en),
		.pid_update_en   (pid_update_en),
		.trig            (trig),
		.pipe_out        (pipe_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;                            // 100 MHz
	end

	////////////////////////////////////////
	// error reporting
	////////////////////////////////////////

	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(string what, logic [95:0] got, logic [95:0] exp);
		$display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
		stop_run();
	endtask

	task automatic report_error(string msg);
		$display("error at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_rsp(host_rsp_t got, ep_data_t exp_data, logic exp_err);
		if (got.err !== exp_err) report_value("rsp err", got.err, exp_err);
		if (got.data !== exp_data) report_value("rsp data", got.data, exp_data);
	endtask

	task automatic check_pid_cfg(pid_cfg_t got, pid_cfg_t exp);
		if (got !== exp) report_value("pid_cfg", got, exp);
	endtask

	task automatic check_osf_cfg(osf_cfg_t got, osf_cfg_t exp);
		if (got !== exp) report_value("osf_cfg", got, exp);
	endtask

	task automatic check_adc_cfg(adc_cfg_t got, adc_cfg_t exp);
		if (got !== exp) report_value("adc_cfg", got, exp);
	endtask

	task automatic check_mask(string what, chan_mask_t got, chan_mask_t exp);
		if (got !== exp) report_value(what, got, exp);
	endtask

	task automatic check_trig(trig_t got, trig_t exp);
		if (got !== exp) report_value("trig", got, exp);
	endtask

	task automatic check_pipe(ep_data_t got, ep_data_t exp);
		if (got !== exp) report_value("pipe word", got, exp);
	endtask

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);          // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic load_tests();
		int          fd;
		int          n;
		string       line;
		step_t       s;
		logic [31:0] f_op, f_addr, f_data, f_exp, f_err;
		fd = $fopen("testbench/fp_tests.txt", "r");
		if (fd == 0) report_error("cannot open testbench/fp_tests.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_exp, f_err);
				if (n == 5) begin
					s.op   = f_op[3:0];
					s.addr = f_addr[W_ADDR-1:0];
					s.data = f_data[W_EP-1:0];
					s.exp  = f_exp[W_EP-1:0];
					s.err  = f_err[0];
					steps.push_back(s);
				end
			end
		end
		$fclose(fd);
	endtask

	// one request, returns at the negedge after the response edge
	task automatic host_access(host_op_t op, ep_addr_t addr, ep_data_t data,
			output host_rsp_t rsp);
		int waited;
		waited = 0;
		@(posedge clk);
		host_req <= '{valid: 1'b1, op: op, addr: addr, data: data};
		@(posedge clk);
		host_req.valid <= 1'b0;                           // accept edge
		@(negedge clk);
		while (!host_rsp.valid) begin
			waited++;
			if (waited > RSP_LATENCY) report_error("host request got no response");
			@(negedge clk);
		end
		if (waited != RSP_LATENCY) report_error("response came early");
		rsp = host_rsp;
	endtask

	// one cycle of samples, valid stays up until the caller drops it
	task automatic drive_samples(chan_mask_t mask);
		logic [31:0]           bits;
		adc_data_t [N_ADC-1:0] data;
		for (int i = 0; i < N_ADC; i++) begin
			take_bits(W_ADC_DATA, bits);
			data[i] = bits[W_ADC_DATA-1:0];
			if (mask[i]) exp_chan[i] = data[i][W_ADC_DATA-1 -: W_EP];
		end
		// no credits while streaming, so queue size is the fifo level
		if (mask[exp_sel] && exp_pipe.size() < FIFO_DEPTH) begin
			exp_pipe.push_back(data[exp_sel][W_ADC_DATA-1 -: W_EP]);
		end
		@(posedge clk);
		osf_valid       <= mask;
		osf_data_packed <= data;
	endtask

	task automatic wait_pipe_words(int count);
		int target;
		int waited;
		target = rx_mark + count;
		waited = 0;
		while (rx_count < target) begin
			@(posedge clk);
			waited++;
			if (waited > CYCLES_PER_STEP) report_error("pipe words missing");
		end
		repeat (QUIET_CYCLES) @(posedge clk);
		if (rx_count != target) report_error("pipe sent more words than granted");
		rx_mark = target;
	endtask

	task automatic update_model(step_t s);
		if (s.op == OP_WIRE_IN && !s.err) begin
			case (s.addr)
				ADC_OS_WEP:          exp_adc.os          = s.data[W_ADC_OS-1:0];
				OSF_ACTIVATE_WEP:    exp_osf.activate    = s.data[N_ADC-1:0];
				OSF_CYCLE_DELAY_WEP: exp_osf.cycle_delay = s.data;
				OSF_OSM_WEP:         exp_osf.osm         = s.data[W_OSM-1:0];
				PID_LOCK_EN_WEP:     exp_pid.lock_en     = s.data[N_ADC-1:0];
				PID_SETPOINT_WEP:    exp_pid.setpoint    = s.data;
				PID_P_COEF_WEP:      exp_pid.p_coef      = s.data;
				PID_I_COEF_WEP:      exp_pid.i_coef      = s.data;
				PID_D_COEF_WEP:      exp_pid.d_coef      = s.data;
				PIPE_CHAN_SEL_WEP:   exp_sel             = s.data[W_CHAN_SEL-1:0];
				default: ;
			endcase
		end
		if (s.op == OP_PIPE_CREDIT) granted += s.data[W_CREDIT-1:0];
		// sys_reset flushes fifo and credits
		if (s.op == OP_TRIG_IN && s.addr == SYS_RESET_TEP && s.data[0]) begin
			exp_pipe.delete();
			granted  = 0;
			rx_count = 0;
			rx_mark  = 0;
		end
	endtask

	task automatic run_step(step_t s);
		host_rsp_t rsp;
		ep_data_t  exp_data;
		host_op_t  op;
		exp_data = '0;
		op       = (s.op == STEP_READ_CH) ? OP_WIRE_OUT : host_op_t'(s.op[1:0]);
		case (s.op)
			STEP_SAMPLES: begin
				drive_samples(s.data[N_ADC-1:0]);
				@(posedge clk);
				osf_valid <= '0;
			end
			STEP_STREAM: begin
				for (int i = 0; i < int'(s.data); i++) begin
					drive_samples(chan_mask_t'(1) << exp_sel);  // back to back
				end
				@(posedge clk);
				osf_valid <= '0;
			end
			STEP_DRAIN: wait_pipe_words(int'(s.data));
			OP_WIRE_IN, OP_TRIG_IN, OP_WIRE_OUT, OP_PIPE_CREDIT, STEP_READ_CH: begin
				if (s.op == OP_WIRE_OUT) exp_data = s.exp;
				if (s.op == STEP_READ_CH) exp_data = exp_chan[s.addr[W_CHAN_SEL-1:0]];
				host_access(op, s.addr, s.data, rsp);
				update_model(s);
				check_rsp(rsp, exp_data, s.err);
				// pulses land with the response
				check_trig(trig, (s.op == OP_TRIG_IN) ? trig_t'(s.exp[10:0]) : trig_t'(0));
				check_mask("osf_update_en", osf_update_en,
					(s.op == OP_WIRE_IN) ? s.exp[7:0] : chan_mask_t'(0));
				check_mask("pid_update_en", pid_update_en,
					(s.op == OP_WIRE_IN) ? s.exp[15:8] : chan_mask_t'(0));
				check_adc_cfg(adc_cfg, exp_adc);
				check_osf_cfg(osf_cfg, exp_osf);
				check_pid_cfg(pid_cfg, exp_pid);
				@(negedge clk);
				check_trig(trig, '0);                     // gone one cycle later
				check_mask("osf_update_en", osf_update_en, '0);
				check_mask("pid_update_en", pid_update_en, '0);
			end
			default: report_error("unknown step code in test file");
		endcase
	endtask

	////////////////////////////////////////
	// pipe monitor, watchdog, main
	////////////////////////////////////////

	always @(negedge clk) begin
		if (!rst && pipe_out.valid) begin
			rx_count++;
			if (rx_count > granted) report_error("pipe word sent without a credit");
			if (exp_pipe.size() == 0) begin
				report_error("pipe word arrived with nothing queued");
			end else begin
				check_pipe(pipe_out.data, exp_pipe.pop_front());
			end
		end
	end

	initial begin
		wait (loaded);
		repeat (step_limit) @(posedge clk);
		$display("watchdog: run exceeded %0d cycles", step_limit);
		$display("** FAIL **");
		$fatal(1, "timeout");
	end

	initial begin
		host_req        = '0;
		osf_valid       = '0;
		osf_data_packed = '0;
		rst             = 1'b1;
		granted         = 0;
		rx_count        = 0;
		rx_mark         = 0;
		exp_adc         = '0;
		exp_osf         = '0;
		exp_pid         = '0;
		exp_sel         = '0;
		lfsr_state      = LFSR_SEED;
		foreach (exp_chan[i]) exp_chan[i] = '0;
		load_tests();
		step_limit = CYCLES_PER_STEP * steps.size() + CYCLES_BASE;
		loaded     = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		// everything idle out of reset
		if (host_rsp.valid || pipe_out.valid) report_error("valid set after reset");
		check_trig(trig, '0);
		check_mask("osf_update_en", osf_update_en, '0);
		check_mask("pid_update_en", pid_update_en, '0);
		check_pid_cfg(pid_cfg, '0);
		foreach (steps[i]) run_step(steps[i]);
		repeat (4) @(posedge clk);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/endpoint_regs.sv ====
`default_nettype none

module endpoint_regs (
	input  wire                          clk50_in,
	input  wire                          rst,
	input  wire                          reg_wr,
	input  wire                          trig_wr,
	input  wire fp_types_pkg::ep_addr_t  reg_addr,
	input  wire fp_types_pkg::ep_data_t  reg_wdata,
	input  wire fp_types_pkg::chan_mask_t osf_valid,
	input  wire fp_types_pkg::adc_data_t [fp_types_pkg::N_ADC-1:0] osf_data_packed,
	input  wire [fp_types_pkg::W_FIFO_LEVEL-1:0] fifo_level,
	input  wire                          overflow,
	input  wire                          credit_avail,
	output fp_types_pkg::ep_data_t       rd_data,
	output logic                         rd_hit,
	output fp_types_pkg::adc_cfg_t       adc_cfg,
	output fp_types_pkg::osf_cfg_t       osf_cfg,
	output fp_types_pkg::pid_cfg_t       pid_cfg,
	output fp_types_pkg::chan_mask_t     osf_update_en,
	output fp_types_pkg::chan_mask_t     pid_update_en,
	output fp_types_pkg::trig_t          trig,
	output logic [fp_types_pkg::W_CHAN_SEL-1:0] pipe_chan_sel
);

	import fp_types_pkg::*;
	import fp_ep_map_pkg::*;

	chan_mask_t osf_update_mask;                       // channels told of osf changes
	chan_mask_t pid_update_mask;
	ep_data_t   sample_q [N_ADC];                      // top bits of newest sample
	logic       osf_chg, pid_chg;                      // addressed value would change
	logic       wi_hit, wo_hit, tr_hit, smp_hit;

	////////////////////////////////////////
	// address decode and readback
	////////////////////////////////////////

	assign wi_hit  = (reg_addr <= PID_UPDATE_MASK_WEP);
	assign smp_hit = (reg_addr >= OSF_DATA0_OWEP) && (reg_addr < OSF_DATA0_OWEP + N_ADC);
	assign wo_hit  = smp_hit || (reg_addr == STATUS_OWEP);
	assign tr_hit  = (reg_addr >= ADC_CSTART_TEP) && (reg_addr <= SYS_RESET_TEP);

	// writes only match their own space, reads see wire-ins too
	assign rd_hit = trig_wr ? tr_hit : reg_wr ? wi_hit : (wi_hit || wo_hit);

	always_comb begin
		rd_data = '0;
		if (smp_hit) begin
			rd_data = sample_q[reg_addr[W_CHAN_SEL-1:0]];
		end else begin
			case (reg_addr)
				ADC_OS_WEP:          rd_data = ep_data_t'(adc_cfg.os);
				OSF_ACTIVATE_WEP:    rd_data = ep_data_t'(osf_cfg.activate);
				OSF_CYCLE_DELAY_WEP: rd_data = osf_cfg.cycle_delay;
				OSF_OSM_WEP:         rd_data = ep_data_t'(osf_cfg.osm);
				PID_LOCK_EN_WEP:     rd_data = ep_data_t'(pid_cfg.lock_en);
				PID_SETPOINT_WEP:    rd_data = pid_cfg.setpoint;
				PID_P_COEF_WEP:      rd_data = pid_cfg.p_coef;
				PID_I_COEF_WEP:      rd_data = pid_cfg.i_coef;
				PID_D_COEF_WEP:      rd_data = pid_cfg.d_coef;
				PIPE_CHAN_SEL_WEP:   rd_data = ep_data_t'(pipe_chan_sel);
				OSF_UPDATE_MASK_WEP: rd_data = ep_data_t'(osf_update_mask);
				PID_UPDATE_MASK_WEP: rd_data = ep_data_t'(pid_update_mask);
				STATUS_OWEP: begin
					rd_data[ST_LEVEL_LSB +: W_FIFO_LEVEL] = fifo_level;
					rd_data[ST_OVERFLOW_BIT]              = overflow;
					rd_data[ST_CREDIT_BIT]                = credit_avail;
				end
				default: rd_data = '0;
			endcase
		end
	end

	// change detect against the stored value
	always_comb begin
		osf_chg = 1'b0;
		pid_chg = 1'b0;
		case (reg_addr)
			OSF_ACTIVATE_WEP:    osf_chg = reg_wdata[N_ADC-1:0] != osf_cfg.activate;
			OSF_CYCLE_DELAY_WEP: osf_chg = reg_wdata != osf_cfg.cycle_delay;
			OSF_OSM_WEP:         osf_chg = reg_wdata[W_OSM-1:0] != osf_cfg.osm;
			PID_LOCK_EN_WEP:     pid_chg = reg_wdata[N_ADC-1:0] != pid_cfg.lock_en;
			PID_SETPOINT_WEP:    pid_chg = reg_wdata != pid_cfg.setpoint;
			PID_P_COEF_WEP:      pid_chg = reg_wdata != pid_cfg.p_coef;
			PID_I_COEF_WEP:      pid_chg = reg_wdata != pid_cfg.i_coef;
			PID_D_COEF_WEP:      pid_chg = reg_wdata != pid_cfg.d_coef;
			default: ;
		endcase
	end

	////////////////////////////////////////
	// wire-in registers
	////////////////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (rst) begin
			adc_cfg         <= '0;
			osf_cfg         <= '0;
			pid_cfg         <= '0;
			pipe_chan_sel   <= '0;
			osf_update_mask <= '0;
			pid_update_mask <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				ADC_OS_WEP:          adc_cfg.os          <= reg_wdata[W_ADC_OS-1:0];
				OSF_ACTIVATE_WEP:    osf_cfg.activate    <= reg_wdata[N_ADC-1:0];
				OSF_CYCLE_DELAY_WEP: osf_cfg.cycle_delay <= reg_wdata;
				OSF_OSM_WEP:         osf_cfg.osm         <= reg_wdata[W_OSM-1:0];
				PID_LOCK_EN_WEP:     pid_cfg.lock_en     <= reg_wdata[N_ADC-1:0];
				PID_SETPOINT_WEP:    pid_cfg.setpoint    <= reg_wdata;
				PID_P_COEF_WEP:      pid_cfg.p_coef      <= $signed(reg_wdata);
				PID_I_COEF_WEP:      pid_cfg.i_coef      <= $signed(reg_wdata);
				PID_D_COEF_WEP:      pid_cfg.d_coef      <= $signed(reg_wdata);
				PIPE_CHAN_SEL_WEP:   pipe_chan_sel       <= reg_wdata[W_CHAN_SEL-1:0];
				OSF_UPDATE_MASK_WEP: osf_update_mask     <= reg_wdata[N_ADC-1:0];
				PID_UPDATE_MASK_WEP: pid_update_mask     <= reg_wdata[N_ADC-1:0];
				default: ;
			endcase
		end
	end

	// one-cycle pulses, land with the write
	always_ff @(posedge clk50_in) begin
		if (rst) begin
			osf_update_en <= '0;
			pid_update_en <= '0;
			trig          <= '0;
		end else begin
			osf_update_en <= (reg_wr && osf_chg) ? osf_update_mask : '0;
			pid_update_en <= (reg_wr && pid_chg) ? pid_update_mask : '0;
			trig          <= '0;
			if (trig_wr) begin
				case (reg_addr)
					ADC_CSTART_TEP:    trig.adc_cstart    <= reg_wdata[0];
					PID_CLEAR_TEP:     trig.pid_clear     <= reg_wdata[N_ADC-1:0];
					MODULE_UPDATE_TEP: trig.module_update <= reg_wdata[0];
					SYS_RESET_TEP:     trig.sys_reset     <= reg_wdata[0];
					default: ;
				endcase
			end
		end
	end

	// newest sample per channel, top 16 of 18 bits
	always_ff @(posedge clk50_in) begin
		for (int i = 0; i < N_ADC; i++) begin
			if (rst) begin
				sample_q[i] <= '0;
			end else if (osf_valid[i]) begin
				sample_q[i] <= osf_data_packed[i][W_ADC_DATA-1 -: W_EP];
			end
		end
	end

	// rd_hit decode needs at most one strobe
	a_single_strobe: assert property (
		@(posedge clk50_in) disable iff (rst)
		!(reg_wr && trig_wr)
	);

endmodule

`default_nettype wire

// ==== verilog/fp_ep_map_pkg.sv ====
`default_nettype none

package fp_ep_map_pkg;

	import fp_types_pkg::*;

	// host operations
	localparam host_op_t OP_WIRE_IN     = 2'd0;
	localparam host_op_t OP_TRIG_IN     = 2'd1;
	localparam host_op_t OP_WIRE_OUT    = 2'd2;
	localparam host_op_t OP_PIPE_CREDIT = 2'd3;

	////////////////////////////////////////
	// wire-ins, readable through wire-out
	////////////////////////////////////////

	localparam ep_addr_t ADC_OS_WEP          = 8'h00;
	localparam ep_addr_t OSF_ACTIVATE_WEP    = 8'h01;
	localparam ep_addr_t OSF_CYCLE_DELAY_WEP = 8'h02;
	localparam ep_addr_t OSF_OSM_WEP         = 8'h03;
	localparam ep_addr_t PID_LOCK_EN_WEP     = 8'h04;
	localparam ep_addr_t PID_SETPOINT_WEP    = 8'h05;
	localparam ep_addr_t PID_P_COEF_WEP      = 8'h06;
	localparam ep_addr_t PID_I_COEF_WEP      = 8'h07;
	localparam ep_addr_t PID_D_COEF_WEP      = 8'h08;
	localparam ep_addr_t PIPE_CHAN_SEL_WEP   = 8'h09;
	localparam ep_addr_t OSF_UPDATE_MASK_WEP = 8'h0A;
	localparam ep_addr_t PID_UPDATE_MASK_WEP = 8'h0B;  // last wire-in

	// triggers, one address per target
	localparam ep_addr_t ADC_CSTART_TEP      = 8'h40;
	localparam ep_addr_t PID_CLEAR_TEP       = 8'h41;
	localparam ep_addr_t MODULE_UPDATE_TEP   = 8'h42;
	localparam ep_addr_t SYS_RESET_TEP       = 8'h43;

	// wire-outs, base must stay aligned to N_ADC
	localparam ep_addr_t OSF_DATA0_OWEP      = 8'h20;
	localparam ep_addr_t STATUS_OWEP         = 8'h28;

	// status word layout
	localparam int ST_LEVEL_LSB    = 0;                // level in 4:0
	localparam int ST_OVERFLOW_BIT = 8;
	localparam int ST_CREDIT_BIT   = 9;

endpackage

`default_nettype wire

// ==== verilog/fp_types_pkg.sv ====
`default_nettype none

package fp_types_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////

	localparam int N_ADC        = 8;                   // adc channels
	localparam int W_ADC_DATA   = 18;                  // filtered sample width
	localparam int W_EP         = 16;                  // endpoint word
	localparam int W_ADDR       = 8;                   // endpoint address
	localparam int W_OP         = 2;                   // host op code
	localparam int W_ADC_OS     = 3;                   // adc oversample code
	localparam int W_OSM        = 6;                   // osf oversample ratio
	localparam int FIFO_DEPTH   = 16;                  // pipe fifo words
	localparam int W_CREDIT     = 8;                   // pipe credit count
	localparam int W_CHAN_SEL   = $clog2(N_ADC);
	localparam int W_FIFO_PTR   = $clog2(FIFO_DEPTH);
	localparam int W_FIFO_LEVEL = W_FIFO_PTR + 1;      // 0..FIFO_DEPTH

	////////////////////////////////////////
	// plain vectors
	////////////////////////////////////////

	typedef logic [W_ADC_DATA-1:0] adc_data_t;
	typedef logic [W_EP-1:0]       ep_data_t;
	typedef logic [W_ADDR-1:0]     ep_addr_t;
	typedef logic [W_OP-1:0]       host_op_t;
	typedef logic [N_ADC-1:0]      chan_mask_t;        // one bit per channel
	typedef logic [W_CREDIT-1:0]   credit_t;

	////////////////////////////////////////
	// bundles
	////////////////////////////////////////

	typedef struct packed {
		logic     valid;
		host_op_t op;
		ep_addr_t addr;
		ep_data_t data;
	} host_req_t;                                      // 27 bits

	typedef struct packed {
		logic     valid;
		logic     err;                                 // address missed the map
		ep_data_t data;
	} host_rsp_t;                                      // 18 bits

	typedef struct packed {
		logic     valid;
		ep_data_t data;
	} pipe_word_t;

	typedef struct packed {
		logic [W_ADC_OS-1:0] os;
	} adc_cfg_t;

	typedef struct packed {
		chan_mask_t       activate;
		ep_data_t         cycle_delay;
		logic [W_OSM-1:0] osm;
	} osf_cfg_t;

	typedef struct packed {
		chan_mask_t              lock_en;
		ep_data_t                setpoint;
		logic signed [W_EP-1:0]  p_coef;
		logic signed [W_EP-1:0]  i_coef;
		logic signed [W_EP-1:0]  d_coef;
	} pid_cfg_t;

	typedef struct packed {
		logic       adc_cstart;
		chan_mask_t pid_clear;
		logic       module_update;                     // any parameter changed
		logic       sys_reset;                         // also flushes the pipe
	} trig_t;

endpackage

`default_nettype wire

// ==== verilog/frontpanel_interface.sv ====
`default_nettype none

module frontpanel_interface (
	input  wire                           clk50_in,
	input  wire                           rst,
	input  wire fp_types_pkg::host_req_t  host_req,
	output fp_types_pkg::host_rsp_t       host_rsp,
	input  wire fp_types_pkg::chan_mask_t osf_valid,
	input  wire fp_types_pkg::adc_data_t [fp_types_pkg::N_ADC-1:0] osf_data_packed,
	output fp_types_pkg::adc_cfg_t        adc_cfg,
	output fp_types_pkg::osf_cfg_t        osf_cfg,
	output fp_types_pkg::pid_cfg_t        pid_cfg,
	output fp_types_pkg::chan_mask_t      osf_update_en,
	output fp_types_pkg::chan_mask_t      pid_update_en,
	output fp_types_pkg::trig_t           trig,
	output fp_types_pkg::pipe_word_t      pipe_out
);

	import fp_types_pkg::*;

	////////////////////////////////////////
	// internal wires
	////////////////////////////////////////

	logic                    reg_wr, trig_wr;
	ep_addr_t                reg_addr;
	ep_data_t                reg_wdata;
	ep_data_t                rd_data;
	logic                    rd_hit;
	credit_t                 credit_add;
	logic                    credit_add_valid;
	logic                    credit_avail;
	logic                    pop;
	logic [W_FIFO_LEVEL-1:0] fifo_level;
	logic                    overflow;
	logic [W_CHAN_SEL-1:0]   pipe_chan_sel;

	host_cmd_fsm u_cmd (
		.clk50_in         (clk50_in),
		.rst              (rst),
		.host_req         (host_req),
		.host_rsp         (host_rsp),
		.reg_wr           (reg_wr),
		.trig_wr          (trig_wr),
		.reg_addr         (reg_addr),
		.reg_wdata        (reg_wdata),
		.rd_data          (rd_data),
		.rd_hit           (rd_hit),
		.credit_add       (credit_add),
		.credit_add_valid (credit_add_valid)
	);

	// sys_reset trigger doubles as pipe flush
	pipe_credit_counter u_credit (
		.clk50_in         (clk50_in),
		.rst              (rst),
		.flush            (trig.sys_reset),
		.credit_add       (credit_add),
		.credit_add_valid (credit_add_valid),
		.pop              (pop),
		.credit_avail     (credit_avail)
	);

	endpoint_regs u_regs (
		.clk50_in         (clk50_in),
		.rst              (rst),
		.reg_wr           (reg_wr),
		.trig_wr          (trig_wr),
		.reg_addr         (reg_addr),
		.reg_wdata        (reg_wdata),
		.osf_valid        (osf_valid),
		.osf_data_packed  (osf_data_packed),
		.fifo_level       (fifo_level),
		.overflow         (overflow),
		.credit_avail     (credit_avail),
		.rd_data          (rd_data),
		.rd_hit           (rd_hit),
		.adc_cfg          (adc_cfg),
		.osf_cfg          (osf_cfg),
		.pid_cfg          (pid_cfg),
		.osf_update_en    (osf_update_en),
		.pid_update_en    (pid_update_en),
		.trig             (trig),
		.pipe_chan_sel    (pipe_chan_sel)
	);

	pipe_tx_fifo u_pipe (
		.clk50_in         (clk50_in),
		.rst              (rst),
		.flush            (trig.sys_reset),
		.osf_valid        (osf_valid),
		.osf_data_packed  (osf_data_packed),
		.pipe_chan_sel    (pipe_chan_sel),
		.credit_avail     (credit_avail),
		.pop              (pop),
		.fifo_level       (fifo_level),
		.overflow         (overflow),
		.pipe_out         (pipe_out)
	);

endmodule

`default_nettype wire

// ==== verilog/host_cmd_fsm.sv ====
`default_nettype none

module host_cmd_fsm (
	input  wire                       clk50_in,
	input  wire                       rst,
	input  wire fp_types_pkg::host_req_t host_req,
	output fp_types_pkg::host_rsp_t   host_rsp,
	output logic                      reg_wr,
	output logic                      trig_wr,
	output fp_types_pkg::ep_addr_t    reg_addr,
	output fp_types_pkg::ep_data_t    reg_wdata,
	input  wire fp_types_pkg::ep_data_t rd_data,
	input  wire                       rd_hit,
	output fp_types_pkg::credit_t     credit_add,
	output logic                      credit_add_valid
);

	import fp_types_pkg::*;
	import fp_ep_map_pkg::*;

	typedef enum logic [1:0] {
		FSM_IDLE,                                      // waiting for a request
		FSM_EXEC,                                      // request latched, strobe issued
		FSM_RESP                                       // strobe live, response built
	} fsm_state_t;

	fsm_state_t state;
	host_req_t  req_q;                                 // held for the whole transaction

	// latched request drives the datapath
	assign reg_addr   = req_q.addr;
	assign reg_wdata  = req_q.data;
	assign credit_add = req_q.data[W_CREDIT-1:0];

	// payload capture on accept
	always_ff @(posedge clk50_in) begin
		if (state == FSM_IDLE && host_req.valid) begin
			req_q <= host_req;
		end
	end

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (rst) begin
			state            <= FSM_IDLE;
			reg_wr           <= 1'b0;
			trig_wr          <= 1'b0;
			credit_add_valid <= 1'b0;
			host_rsp         <= '0;
		end else begin
			// strobes and rsp valid live for one cycle
			reg_wr           <= 1'b0;
			trig_wr          <= 1'b0;
			credit_add_valid <= 1'b0;
			host_rsp.valid   <= 1'b0;
			case (state)
				FSM_IDLE: begin
					if (host_req.valid) state <= FSM_EXEC;
				end
				FSM_EXEC: begin
					// exactly one strobe, wire-out needs none
					reg_wr           <= (req_q.op == OP_WIRE_IN);
					trig_wr          <= (req_q.op == OP_TRIG_IN);
					credit_add_valid <= (req_q.op == OP_PIPE_CREDIT);
					state            <= FSM_RESP;
				end
				FSM_RESP: begin
					host_rsp.valid <= 1'b1;
					host_rsp.err   <= (req_q.op != OP_PIPE_CREDIT) && !rd_hit;
					host_rsp.data  <= (req_q.op == OP_WIRE_OUT) ? rd_data : '0;
					state          <= FSM_IDLE;
				end
				default: state <= FSM_IDLE;
			endcase
		end
	end

	// host keeps one request outstanding
	a_one_outstanding: assert property (
		@(posedge clk50_in) disable iff (rst)
		host_req.valid |-> state == FSM_IDLE
	);

endmodule

`default_nettype wire

// ==== verilog/pipe_credit_counter.sv ====
`default_nettype none

module pipe_credit_counter (
	input  wire                        clk50_in,
	input  wire                        rst,
	input  wire                        flush,
	input  wire fp_types_pkg::credit_t credit_add,
	input  wire                        credit_add_valid,
	input  wire                        pop,
	output logic                       credit_avail
);

	import fp_types_pkg::*;

	credit_t             count;                        // granted, not yet sent
	logic [W_CREDIT:0]   next_sum;                     // one spare bit for saturation

	// grant and pop may land together
	always_comb begin
		next_sum = {1'b0, count} - (W_CREDIT + 1)'(pop);
		if (credit_add_valid) next_sum = next_sum + {1'b0, credit_add};
	end

	always_ff @(posedge clk50_in) begin
		if (rst || flush) begin
			count <= '0;
		end else if (next_sum[W_CREDIT]) begin
			count <= '1;                               // clamp at 255
		end else begin
			count <= next_sum[W_CREDIT-1:0];
		end
	end

	assign credit_avail = (count != '0);

	// fifo must never send past the grant
	a_no_pop_at_zero: assert property (
		@(posedge clk50_in) disable iff (rst)
		pop |-> count != '0
	);

endmodule

`default_nettype wire

// ==== verilog/pipe_tx_fifo.sv ====
`default_nettype none

module pipe_tx_fifo (
	input  wire                           clk50_in,
	input  wire                           rst,
	input  wire                           flush,
	input  wire fp_types_pkg::chan_mask_t osf_valid,
	input  wire fp_types_pkg::adc_data_t [fp_types_pkg::N_ADC-1:0] osf_data_packed,
	input  wire [fp_types_pkg::W_CHAN_SEL-1:0] pipe_chan_sel,
	input  wire                           credit_avail,
	output logic                          pop,
	output logic [fp_types_pkg::W_FIFO_LEVEL-1:0] fifo_level,
	output logic                          overflow,
	output fp_types_pkg::pipe_word_t      pipe_out
);

	import fp_types_pkg::*;

	ep_data_t              mem [FIFO_DEPTH];
	logic [W_FIFO_PTR-1:0] wr_ptr, rd_ptr;            // wrap naturally
	adc_data_t             sel_sample;
	logic                  sel_valid;
	logic                  full;
	logic                  push;

	// channel mux
	assign sel_sample = osf_data_packed[pipe_chan_sel];
	assign sel_valid  = osf_valid[pipe_chan_sel];

	assign full = (fifo_level == W_FIFO_LEVEL'(FIFO_DEPTH));
	assign push = sel_valid && !full;                  // full drops the sample
	assign pop  = (fifo_level != '0) && credit_avail;  // one word per credit

	always_ff @(posedge clk50_in) begin
		if (push) mem[wr_ptr] <= sel_sample[W_ADC_DATA-1 -: W_EP];
	end

	////////////////////////////////////////
	// pointers, level, output word
	////////////////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (rst || flush) begin
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			fifo_level     <= '0;
			overflow       <= 1'b0;
			pipe_out.valid <= 1'b0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) begin
				rd_ptr        <= rd_ptr + 1'b1;
				pipe_out.data <= mem[rd_ptr];
			end
			fifo_level     <= fifo_level + W_FIFO_LEVEL'(push) - W_FIFO_LEVEL'(pop);
			pipe_out.valid <= pop;
			if (sel_valid && full) overflow <= 1'b1;  // sticky until flush
		end
	end

	a_level_bound: assert property (
		@(posedge clk50_in) disable iff (rst)
		fifo_level <= W_FIFO_LEVEL'(FIFO_DEPTH)
	);

endmodule

`default_nettype wire
